//--- rtl/global_buffer_pkg.sv
// shared widths, tile and register counts, cycle latencies, bridge state codes
package global_buffer_pkg;

    // tile chain
    localparam int NUM_TILES = 2;
    localparam int TILE_SEL_ADDR_WIDTH = 1;

    // configuration bank per tile
    localparam int CFG_REG_ADDR_WIDTH = 3;
    localparam int NUM_CFG_REGS = 1 << CFG_REG_ADDR_WIDTH;
    localparam int CFG_DATA_WIDTH = 32;

    // wishbone word address, tile index above word index
    localparam int WB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + CFG_REG_ADDR_WIDTH;

    // flattened read packet, valid in the msb
    localparam int PC_PKT_WIDTH = 1 + TILE_SEL_ADDR_WIDTH + CFG_REG_ADDR_WIDTH + CFG_DATA_WIDTH;

    // sampled strobe to registered ack
    localparam int WR_LATENCY = 1;
    localparam int RD_LATENCY = 4;

    // bridge fsm
    localparam logic [1:0] BR_IDLE = 2'd0;
    localparam logic [1:0] BR_WR_ACK = 2'd1;
    localparam logic [1:0] BR_RD_WAIT = 2'd2;

endpackage

//--- rtl/pc_packet_if.sv
// read packet bundle with source and sink modports
interface pc_packet_if;
    import global_buffer_pkg::*;

    // packet qualifier
    logic valid;
    // tile that emitted the packet
    logic [TILE_SEL_ADDR_WIDTH-1:0] tile;
    // word index inside that tile
    logic [CFG_REG_ADDR_WIDTH-1:0] addr;
    logic [CFG_DATA_WIDTH-1:0] data;

    // driving side
    modport src (
        output valid, tile, addr, data
    );

    // receiving side
    modport dst (
        input valid, tile, addr, data
    );

endinterface

//--- rtl/glb_core_pc_store.sv
// per-tile configuration word bank with write port and read packet output
module glb_core_pc_store #(
    parameter int TILE_ID = 0
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             wr_en,
    input  logic                                             rd_req,
    input  logic [global_buffer_pkg::CFG_REG_ADDR_WIDTH-1:0] addr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]     wdata,
    pc_packet_if.src                                         pkt
);
    import global_buffer_pkg::*;

    // word bank, all zero after reset
    logic [CFG_DATA_WIDTH-1:0] cfg_mem [NUM_CFG_REGS];

    // host write lands directly
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_CFG_REGS; i++) begin
                cfg_mem[i] <= '0;
            end
        end else if (wr_en) begin
            cfg_mem[addr] <= wdata;
        end
    end

    // packet valid for one cycle after rd_req
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt.valid <= 1'b0;
        end else begin
            pkt.valid <= rd_req;
        end
    end

    // packet payload, only loaded on a read
    always_ff @(posedge clk) begin
        if (rd_req) begin
            // stamp own tile so the bridge can check the route
            pkt.tile <= TILE_SEL_ADDR_WIDTH'(TILE_ID);
            pkt.addr <= addr;
            pkt.data <= cfg_mem[addr];
        end
    end

    // bridge strobes one access type per request
    wr_rd_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(wr_en && rd_req)
    ) else $error("store %0d: wr_en and rd_req high together", TILE_ID);

endmodule

//--- rtl/glb_core_pc_router.sv
// per-tile parallel config packet router, parity switching and end turn-around
module glb_core_pc_router #(
    parameter int TILE_ID = 0
) (
    input  logic     clk,
    input  logic     reset,
    pc_packet_if.dst packet_w2e_wsti,
    pc_packet_if.src packet_e2w_wsto,
    pc_packet_if.dst packet_e2w_esti,
    pc_packet_if.src packet_w2e_esto,
    pc_packet_if.dst packet_sw2pcr,
    pc_packet_if.src packet_pcr2sw
);
    import global_buffer_pkg::*;

    // flattened packets, {valid, tile, addr, data}
    logic [PC_PKT_WIDTH-1:0] w2e_wsti;
    logic [PC_PKT_WIDTH-1:0] e2w_esti;
    logic [PC_PKT_WIDTH-1:0] sw2pcr;
    logic [PC_PKT_WIDTH-1:0] sw2pcr_d1;
    logic [PC_PKT_WIDTH-1:0] w2e_wsti_turned;
    logic [PC_PKT_WIDTH-1:0] e2w_esti_turned;
    logic [PC_PKT_WIDTH-1:0] w2e_esto_int;
    logic [PC_PKT_WIDTH-1:0] e2w_wsto_int;
    logic [PC_PKT_WIDTH-1:0] pcr2sw_int;
    logic                    is_even;
    logic                    connected_prev;
    logic                    connected_next;
    logic                    through_valid;

    // position flags from tile index, tile 0 sits at the west end
    assign is_even = ((TILE_ID % 2) == 0);
    assign connected_prev = (TILE_ID != 0);
    assign connected_next = (TILE_ID != NUM_TILES - 1);

    assign w2e_wsti = {packet_w2e_wsti.valid, packet_w2e_wsti.tile,
                       packet_w2e_wsti.addr, packet_w2e_wsti.data};
    assign e2w_esti = {packet_e2w_esti.valid, packet_e2w_esti.tile,
                       packet_e2w_esti.addr, packet_e2w_esti.data};
    assign sw2pcr = {packet_sw2pcr.valid, packet_sw2pcr.tile,
                     packet_sw2pcr.addr, packet_sw2pcr.data};

    // open end, own outgoing traffic comes back in
    assign w2e_wsti_turned = connected_prev ? w2e_wsti : e2w_wsto_int;
    assign e2w_esti_turned = connected_next ? e2w_esti : w2e_esto_int;

    // single pipeline stage on the core side
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sw2pcr_d1 <= '0;
        end else begin
            sw2pcr_d1 <= sw2pcr;
        end
    end

    // even tiles inject eastbound, odd tiles westbound
    assign pcr2sw_int = is_even ? w2e_wsti_turned : e2w_esti_turned;
    assign w2e_esto_int = is_even ? sw2pcr_d1 : w2e_wsti_turned;
    assign e2w_wsto_int = is_even ? e2w_esti_turned : sw2pcr_d1;

    assign {packet_e2w_wsto.valid, packet_e2w_wsto.tile,
            packet_e2w_wsto.addr, packet_e2w_wsto.data} = e2w_wsto_int;
    assign {packet_w2e_esto.valid, packet_w2e_esto.tile,
            packet_w2e_esto.addr, packet_w2e_esto.data} = w2e_esto_int;
    assign {packet_pcr2sw.valid, packet_pcr2sw.tile,
            packet_pcr2sw.addr, packet_pcr2sw.data} = pcr2sw_int;

    // traffic that would share the injecting output
    assign through_valid = is_even ? w2e_wsti_turned[PC_PKT_WIDTH-1]
                                   : e2w_esti_turned[PC_PKT_WIDTH-1];

    // one request in flight across the chain, so no merge on an output
    no_output_collision: assert property (
        @(posedge clk) disable iff (reset)
        !(sw2pcr_d1[PC_PKT_WIDTH-1] && through_valid)
    ) else $error("router %0d: core packet collides with pass-through", TILE_ID);

endmodule

//--- rtl/glb_pc_wb_bridge.sv
// wishbone classic slave, tile/word decode, request sequencing, packet merge
module glb_pc_wb_bridge (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             wb_cyc,
    input  logic                                             wb_stb,
    input  logic                                             wb_we,
    input  logic [global_buffer_pkg::WB_ADDR_WIDTH-1:0]      wb_adr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]     wb_dat_w,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]     wb_dat_r,
    output logic                                             wb_ack,
    output logic [global_buffer_pkg::NUM_TILES-1:0]          wr_en,
    output logic [global_buffer_pkg::NUM_TILES-1:0]          rd_req,
    output logic [global_buffer_pkg::CFG_REG_ADDR_WIDTH-1:0] addr,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]     wdata,
    pc_packet_if.dst                                         pkt_t0,
    pc_packet_if.dst                                         pkt_t1
);
    import global_buffer_pkg::*;

    logic [1:0]                     state;
    logic [TILE_SEL_ADDR_WIDTH-1:0] req_tile;
    logic [CFG_REG_ADDR_WIDTH-1:0]  req_word;
    logic [NUM_TILES-1:0]           tile_onehot;
    logic                           accept;
    logic                           wr_accept;
    logic                           rd_accept;
    logic [TILE_SEL_ADDR_WIDTH-1:0] exp_tile;
    logic                           ret_vld;
    logic [CFG_DATA_WIDTH-1:0]      ret_data;

    // top address bit picks the tile
    assign req_tile = wb_adr[WB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
    assign req_word = wb_adr[CFG_REG_ADDR_WIDTH-1:0];

    always_comb begin
        tile_onehot = '0;
        tile_onehot[req_tile] = 1'b1;
    end

    // stb still held in the ack cycle, skip it there
    assign accept = (state == BR_IDLE) && wb_cyc && wb_stb && !wb_ack;
    assign wr_accept = accept && wb_we;
    assign rd_accept = accept && !wb_we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= BR_IDLE;
            wr_en <= '0;
            rd_req <= '0;
            wb_ack <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            // strobes and ack are single-cycle pulses
            wr_en <= '0;
            rd_req <= '0;
            wb_ack <= 1'b0;
            case (state)
                BR_IDLE: begin
                    if (wr_accept) begin
                        wr_en <= tile_onehot;
                        state <= BR_WR_ACK;
                    end else if (rd_accept) begin
                        rd_req <= tile_onehot;
                        state <= BR_RD_WAIT;
                    end
                end
                BR_WR_ACK: begin
                    // word is in the bank by now
                    wb_ack <= 1'b1;
                    state <= BR_IDLE;
                end
                BR_RD_WAIT: begin
                    if (ret_vld) begin
                        wb_ack <= 1'b1;
                        wb_dat_r <= ret_data;
                        state <= BR_IDLE;
                    end
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

    // request payload and the expected return tag
    always_ff @(posedge clk) begin
        if (accept) begin
            addr <= req_word;
            wdata <= wb_dat_w;
            exp_tile <= req_tile;
        end
    end

    // capture stage on the returned packets
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ret_vld <= 1'b0;
        end else begin
            ret_vld <= pkt_t0.valid || pkt_t1.valid;
        end
    end

    always_ff @(posedge clk) begin
        ret_data <= pkt_t0.valid ? pkt_t0.data : pkt_t1.data;
    end

    // a packet surfaces at exactly one core side
    ret_single: assert property (
        @(posedge clk) disable iff (reset)
        !(pkt_t0.valid && pkt_t1.valid)
    ) else $error("bridge: both tiles return a packet");

    // routed packet carries the requested tile and word
    ret_match_t0: assert property (
        @(posedge clk) disable iff (reset)
        pkt_t0.valid |-> (pkt_t0.tile == exp_tile) && (pkt_t0.addr == addr)
    ) else $error("bridge: tile 0 side returned wrong tag");

    ret_match_t1: assert property (
        @(posedge clk) disable iff (reset)
        pkt_t1.valid |-> (pkt_t1.tile == exp_tile) && (pkt_t1.addr == addr)
    ) else $error("bridge: tile 1 side returned wrong tag");

    // fixed latency through store, router pipeline and capture stage
    rd_ack_latency: assert property (
        @(posedge clk) disable iff (reset)
        rd_accept |=> (!wb_ack)[*RD_LATENCY] ##1 wb_ack
    ) else $error("bridge: read ack not %0d cycles after accept", RD_LATENCY);

    wr_ack_latency: assert property (
        @(posedge clk) disable iff (reset)
        wr_accept |=> (!wb_ack)[*WR_LATENCY] ##1 wb_ack
    ) else $error("bridge: write ack not %0d cycle after accept", WR_LATENCY);

endmodule

//--- rtl/glb_pc_top.sv
// two-tile config read slice, wishbone ports, stores, routers, bridge, packet links
module glb_pc_top (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         wb_cyc,
    input  logic                                         wb_stb,
    input  logic                                         wb_we,
    input  logic [global_buffer_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] wb_dat_w,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] wb_dat_r,
    output logic                                         wb_ack
);
    import global_buffer_pkg::*;

    // per-tile strobes, shared word index and data
    logic [NUM_TILES-1:0]          wr_en;
    logic [NUM_TILES-1:0]          rd_req;
    logic [CFG_REG_ADDR_WIDTH-1:0] addr;
    logic [CFG_DATA_WIDTH-1:0]     wdata;

    // core to router
    pc_packet_if sw2pcr_0 ();
    pc_packet_if sw2pcr_1 ();
    // router to core
    pc_packet_if pcr2sw_0 ();
    pc_packet_if pcr2sw_1 ();
    // tile 0 east <-> tile 1 west
    pc_packet_if link_w2e ();
    pc_packet_if link_e2w ();
    // open chain ends, wired back on themselves and ignored by the router
    pc_packet_if west_end ();
    pc_packet_if east_end ();

    glb_pc_wb_bridge u_bridge (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wr_en    (wr_en),
        .rd_req   (rd_req),
        .addr     (addr),
        .wdata    (wdata),
        .pkt_t0   (pcr2sw_0),
        .pkt_t1   (pcr2sw_1)
    );

    // tile 0, even, injects eastbound
    glb_core_pc_store #(.TILE_ID(0)) u_store_0 (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (wr_en[0]),
        .rd_req (rd_req[0]),
        .addr   (addr),
        .wdata  (wdata),
        .pkt    (sw2pcr_0)
    );

    glb_core_pc_router #(.TILE_ID(0)) u_router_0 (
        .clk             (clk),
        .reset           (reset),
        .packet_w2e_wsti (west_end),
        .packet_e2w_wsto (west_end),
        .packet_e2w_esti (link_e2w),
        .packet_w2e_esto (link_w2e),
        .packet_sw2pcr   (sw2pcr_0),
        .packet_pcr2sw   (pcr2sw_0)
    );

    // tile 1, odd, injects westbound
    glb_core_pc_store #(.TILE_ID(1)) u_store_1 (
        .clk    (clk),
        .reset  (reset),
        .wr_en  (wr_en[1]),
        .rd_req (rd_req[1]),
        .addr   (addr),
        .wdata  (wdata),
        .pkt    (sw2pcr_1)
    );

    glb_core_pc_router #(.TILE_ID(1)) u_router_1 (
        .clk             (clk),
        .reset           (reset),
        .packet_w2e_wsti (link_w2e),
        .packet_e2w_wsto (link_e2w),
        .packet_e2w_esti (east_end),
        .packet_w2e_esto (east_end),
        .packet_sw2pcr   (sw2pcr_1),
        .packet_pcr2sw   (pcr2sw_1)
    );

endmodule

//--- dv/glb_pc_checker.sv
// wishbone-side checker with reference model of both banks, data and latency compare
module glb_pc_checker #(
    parameter int WR_LAT = 1,
    parameter int RD_LAT = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         wb_cyc,
    input  logic                                         wb_stb,
    input  logic                                         wb_we,
    input  logic [global_buffer_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] wb_dat_w,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] wb_dat_r,
    input  logic                                         wb_ack,
    input  logic                                         tbl_chk,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] tbl_exp,
    output int                                           data_errs,
    output int                                           lat_errs,
    output int                                           proto_errs
);
    import global_buffer_pkg::*;

    // model of all 16 words, tile bit on top
    logic [CFG_DATA_WIDTH-1:0] model [1 << WB_ADDR_WIDTH];
    // request seen on the bus and not yet acked
    logic                      busy;
    logic                      req_we;
    logic [WB_ADDR_WIDTH-1:0]  req_adr;
    logic [CFG_DATA_WIDTH-1:0] req_dat;
    logic [CFG_DATA_WIDTH-1:0] exp_dat;
    // edges counted from the accepting edge
    int                        wait_cycles;

    // table entries carry their own expected word, random traffic uses the model
    assign exp_dat = tbl_chk ? tbl_exp : model[req_adr];

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < (1 << WB_ADDR_WIDTH); i++) begin
                model[i] <= '0;
            end
            busy <= 1'b0;
            wait_cycles <= 0;
            data_errs <= 0;
            lat_errs <= 0;
            proto_errs <= 0;
        end else if (wb_ack) begin
            if (!busy) begin
                proto_errs <= proto_errs + 1;
                $display("ERROR: ack seen with no request outstanding at %0t", $time);
            end else begin
                busy <= 1'b0;
                // ack registered one edge before it is seen here
                if (wait_cycles != (req_we ? WR_LAT : RD_LAT)) begin
                    lat_errs <= lat_errs + 1;
                    $display("ERROR: %s ack after %0d cycles, expected %0d",
                             req_we ? "write" : "read", wait_cycles,
                             req_we ? WR_LAT : RD_LAT);
                end
                if (req_we) begin
                    model[req_adr] <= req_dat;
                end else if (wb_dat_r !== exp_dat) begin
                    data_errs <= data_errs + 1;
                    $display("mismatch wb_dat_r adr %h: expected %h, actual %h",
                             req_adr, exp_dat, wb_dat_r);
                end
            end
        end else if (busy) begin
            wait_cycles <= wait_cycles + 1;
        end else if (wb_cyc && wb_stb) begin
            // same edge the bridge accepts on
            busy <= 1'b1;
            wait_cycles <= 0;
            req_we <= wb_we;
            req_adr <= wb_adr;
            req_dat <= wb_dat_w;
        end
    end

endmodule

//--- dv/glb_pc_tb.sv
// testbench top with clock, reset, seeding, stimulus table loop, random phase, watchdog
module glb_pc_tb;
    import global_buffer_pkg::*;

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 8;
    localparam int RD_LAT = 4;
    localparam int WR_LAT = 1;
    localparam int N_RANDOM = 40;

    logic                      clk;
    logic                      reset;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [WB_ADDR_WIDTH-1:0]  wb_adr;
    logic [CFG_DATA_WIDTH-1:0] wb_dat_w;
    logic [CFG_DATA_WIDTH-1:0] wb_dat_r;
    logic                      wb_ack;
    // expected word handed to the checker for table reads
    logic                      tbl_chk;
    logic [CFG_DATA_WIDTH-1:0] tbl_exp;
    int                        data_errs;
    int                        lat_errs;
    int                        proto_errs;
    int unsigned               seed_val;
    logic                      steps_ready;

    // stimulus table, one entry per bus request
    logic                      step_we [$];
    logic [WB_ADDR_WIDTH-1:0]  step_adr [$];
    logic [CFG_DATA_WIDTH-1:0] step_dat [$];
    logic [CFG_DATA_WIDTH-1:0] step_exp [$];

    glb_pc_top uut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    glb_pc_checker #(.WR_LAT(WR_LAT), .RD_LAT(RD_LAT)) chk (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tbl_chk    (tbl_chk),
        .tbl_exp    (tbl_exp),
        .data_errs  (data_errs),
        .lat_errs   (lat_errs),
        .proto_errs (proto_errs)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic add_step(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                            input logic [CFG_DATA_WIDTH-1:0] dat,
                            input logic [CFG_DATA_WIDTH-1:0] exp);
        step_we.push_back(we);
        step_adr.push_back(adr);
        step_dat.push_back(dat);
        step_exp.push_back(exp);
    endtask

    task automatic fill_table();
        // untouched words of both tiles read zero
        add_step(1'b0, 4'h0, 32'h0, 32'h0);
        add_step(1'b0, 4'h9, 32'h0, 32'h0);
        add_step(1'b0, 4'hf, 32'h0, 32'h0);
        // tile 0, eastbound then east-end turn-around
        add_step(1'b1, 4'h3, 32'ha5a5_0003, 32'h0);
        add_step(1'b0, 4'h3, 32'h0, 32'ha5a5_0003);
        // tile 1 same index, westbound then west-end turn-around
        add_step(1'b1, 4'hb, 32'h5a5a_000b, 32'h0);
        add_step(1'b0, 4'hb, 32'h0, 32'h5a5a_000b);
        add_step(1'b0, 4'h3, 32'h0, 32'ha5a5_0003);
        // corners of both banks
        add_step(1'b1, 4'h0, 32'h1111_1111, 32'h0);
        add_step(1'b1, 4'h8, 32'h2222_2222, 32'h0);
        add_step(1'b1, 4'h7, 32'hdead_beef, 32'h0);
        add_step(1'b1, 4'hf, 32'hcafe_f00d, 32'h0);
        add_step(1'b0, 4'h0, 32'h0, 32'h1111_1111);
        add_step(1'b0, 4'h8, 32'h0, 32'h2222_2222);
        add_step(1'b0, 4'h7, 32'h0, 32'hdead_beef);
        add_step(1'b0, 4'hf, 32'h0, 32'hcafe_f00d);
        add_step(1'b0, 4'h1, 32'h0, 32'h0);
        add_step(1'b0, 4'h9, 32'h0, 32'h0);
        // overwrite in tile 0 leaves tile 1 alone
        add_step(1'b1, 4'h3, 32'h0bad_f00d, 32'h0);
        add_step(1'b0, 4'hb, 32'h0, 32'h5a5a_000b);
        add_step(1'b0, 4'h3, 32'h0, 32'h0bad_f00d);
    endtask

    // drive on the current edge, return on the edge where ack is seen
    task automatic issue_request(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                                 input logic [CFG_DATA_WIDTH-1:0] dat, input logic chk,
                                 input logic [CFG_DATA_WIDTH-1:0] exp);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= dat;
        tbl_chk <= chk;
        tbl_exp <= exp;
        @(posedge clk);
        while (!wb_ack) begin
            @(posedge clk);
        end
    endtask

    initial begin
        logic                      rnd_we;
        logic [WB_ADDR_WIDTH-1:0]  rnd_adr;
        logic [CFG_DATA_WIDTH-1:0] rnd_dat;
        clk = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        tbl_chk = 1'b0;
        tbl_exp = '0;
        steps_ready = 1'b0;
        seed_val = $urandom(32'h6eb1);
        fill_table();
        steps_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // quiet bus, checker flags any stray ack
        repeat (IDLE_CYCLES) @(posedge clk);
        // back-to-back, next request starts on the ack edge
        for (int i = 0; i < step_we.size(); i++) begin
            issue_request(step_we[i], step_adr[i], step_dat[i], !step_we[i], step_exp[i]);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd_we = 1'($urandom);
            rnd_adr = WB_ADDR_WIDTH'($urandom);
            rnd_dat = $urandom;
            issue_request(rnd_we, rnd_adr, rnd_dat, 1'b0, '0);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        tbl_chk <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
        $display("errors: %0d data, %0d latency, %0d protocol", data_errs, lat_errs, proto_errs);
        if (data_errs + lat_errs + proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run limit from request count, worst case twice the read latency each
    initial begin
        int limit_cycles;
        wait (steps_ready);
        limit_cycles = (step_we.size() + N_RANDOM) * 2 * RD_LAT + RESET_CYCLES + 2 * IDLE_CYCLES;
        #(limit_cycles * PERIOD);
        $display("ERROR: timeout, run did not finish within %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- project.f
rtl/global_buffer_pkg.sv
rtl/pc_packet_if.sv
rtl/glb_core_pc_store.sv
rtl/glb_core_pc_router.sv
rtl/glb_pc_wb_bridge.sv
rtl/glb_pc_top.sv
dv/glb_pc_checker.sv
dv/glb_pc_tb.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vglb_pc_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module glb_pc_tb -f project.f

run: obj_dir/Vglb_pc_tb
	./obj_dir/Vglb_pc_tb > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
